// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rdma_msn
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
design/rdma_cfg_pkg.sv
design/rdma_pkt_pkg.sv
design/sync_fifo.sv
design/msn_tracker.sv
design/rdma_msn_top.sv
tests/rdma_msn_asserts.sv
tests/tb_rdma_msn.sv

// ==== design/msn_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module msn_tracker (
    input  wire logic                   aclk,
    input  wire logic                   aresetn,

    input  wire logic                   req_valid,
    output logic                        req_ready,
    input  wire rdma_pkt_pkg::rdma_req_t req_data,

    input  wire logic                   ack_valid,
    output logic                        ack_ready,
    input  wire rdma_pkt_pkg::rdma_ack_t ack_data,

    output logic                        out_valid,
    input  wire logic                   out_ready,
    output rdma_pkt_pkg::rdma_req_t     out_data
);

    // per queue pair window state
    logic [rdma_cfg_pkg::WIN_BITS-1:0]  head_q [rdma_cfg_pkg::N_QP];
    logic [rdma_cfg_pkg::WIN_BITS-1:0]  tail_q [rdma_cfg_pkg::N_QP];
    logic [rdma_cfg_pkg::WIN_BITS:0]    cnt_q  [rdma_cfg_pkg::N_QP]; // 0 to 32 outstanding
    logic [rdma_cfg_pkg::WIN_DEPTH-1:0] rd_q   [rdma_cfg_pkg::N_QP]; // read flag per slot
    logic [rdma_cfg_pkg::MSN_BITS-1:0]  ssn_q  [rdma_cfg_pkg::N_QP];
    logic [rdma_cfg_pkg::MSN_BITS-1:0]  msn_q  [rdma_cfg_pkg::N_QP];

    logic [rdma_cfg_pkg::VFID_BITS+rdma_cfg_pkg::PID_BITS-1:0] req_qp;
    logic [rdma_cfg_pkg::VFID_BITS+rdma_cfg_pkg::PID_BITS-1:0] ack_qp;

    logic                               req_is_rd;
    logic [rdma_cfg_pkg::MSN_BITS-1:0]  ack_dist;
    logic                               ack_stale;
    logic [rdma_cfg_pkg::WIN_BITS:0]    fence;
    logic [rdma_cfg_pkg::WIN_BITS:0]    retire;
    logic [rdma_cfg_pkg::WIN_DEPTH-1:0] clr_mask;

    assign req_qp    = {req_data.qp.vfid, req_data.qp.pid};
    assign ack_qp    = {ack_data.qp.vfid, ack_data.qp.pid};
    assign req_is_rd = (req_data.opcode == rdma_pkt_pkg::RC_RDMA_READ_REQUEST);

    // acks are never stalled and always win over requests
    assign ack_ready = ack_valid;
    assign req_ready = !ack_valid && (cnt_q[req_qp] < rdma_cfg_pkg::WIN_DEPTH) && out_ready;
    assign out_valid = req_valid & req_ready;

    always_comb begin
        out_data     = req_data;
        out_data.ssn = ssn_q[req_qp]; // stamp with this queue pair's send sequence number
    end

    // messages ahead of the oldest outstanding read, cnt when there is none
    always_comb begin
        logic [rdma_cfg_pkg::WIN_BITS-1:0] slot;
        fence = cnt_q[ack_qp];
        slot  = '0;
        for (int i = rdma_cfg_pkg::WIN_DEPTH - 1; i >= 0; i--) begin
            slot = tail_q[ack_qp] + i[rdma_cfg_pkg::WIN_BITS-1:0];
            if ((i < cnt_q[ack_qp]) && rd_q[ack_qp][slot]) begin
                fence = i[rdma_cfg_pkg::WIN_BITS:0]; // last hit is the one nearest tail
            end
        end
    end

    // how many messages the offered ack retires
    always_comb begin
        ack_dist  = ack_data.msn - msn_q[ack_qp];
        ack_stale = (ack_dist == '0) || (ack_dist > cnt_q[ack_qp]);
        if (ack_stale) begin
            retire = '0;
        end else if (ack_data.rd) begin
            retire = ack_dist[rdma_cfg_pkg::WIN_BITS:0]; // a read response may pass the fence
        end else if (ack_dist[rdma_cfg_pkg::WIN_BITS:0] < fence) begin
            retire = ack_dist[rdma_cfg_pkg::WIN_BITS:0];
        end else begin
            retire = fence; // plain acks stop just before the oldest read
        end
    end

    // read bits of the slots that are retired now
    always_comb begin
        logic [rdma_cfg_pkg::WIN_BITS-1:0] slot;
        clr_mask = '0;
        slot     = '0;
        for (int i = 0; i < rdma_cfg_pkg::WIN_DEPTH; i++) begin
            slot = tail_q[ack_qp] + i[rdma_cfg_pkg::WIN_BITS-1:0];
            if (i < retire) begin
                clr_mask[slot] = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int q = 0; q < rdma_cfg_pkg::N_QP; q++) begin
                head_q[q] <= '0;
                tail_q[q] <= '0;
                cnt_q[q]  <= '0;
                rd_q[q]   <= '0;
                ssn_q[q]  <= '0;
                msn_q[q]  <= '0;
            end
        end else begin
            // acceptance and retire never share a cycle since req_ready excludes ack_valid
            if (ack_valid && (retire != '0)) begin
                tail_q[ack_qp] <= tail_q[ack_qp] + retire[rdma_cfg_pkg::WIN_BITS-1:0];
                cnt_q[ack_qp]  <= cnt_q[ack_qp] - retire;
                msn_q[ack_qp]  <= msn_q[ack_qp] + retire;
                rd_q[ack_qp]   <= rd_q[ack_qp] & ~clr_mask;
            end
            if (out_valid) begin
                head_q[req_qp]                 <= head_q[req_qp] + 1'b1;
                cnt_q[req_qp]                  <= cnt_q[req_qp] + 1'b1;
                ssn_q[req_qp]                  <= ssn_q[req_qp] + 1'b1;
                rd_q[req_qp][head_q[req_qp]]   <= req_is_rd;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/rdma_cfg_pkg.sv ====
`default_nettype none

package rdma_cfg_pkg;

    // queue pair addressing
    localparam int VFID_BITS = 2; // virtual function id width
    localparam int PID_BITS = 3; // process id width
    localparam int N_QP = 32; // one queue pair per vfid and pid pair

    // outstanding message window
    localparam int WIN_DEPTH = 32; // unacknowledged messages allowed per queue pair
    localparam int WIN_BITS = 5; // slot index width, head and tail wrap on it

    // sequence numbers
    localparam int MSN_BITS = 24; // send and message sequence number width

    // stream buffers
    localparam int FIFO_DEPTH = 4; // entries in each buffer

endpackage

`default_nettype wire

// ==== design/rdma_msn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rdma_msn_top (
    input  wire logic                    aclk,
    input  wire logic                    aresetn,

    input  wire logic                    s_req_valid,
    output logic                         s_req_ready,
    input  wire rdma_pkt_pkg::rdma_req_t s_req_data,

    input  wire logic                    s_ack_valid,
    output logic                         s_ack_ready,
    input  wire rdma_pkt_pkg::rdma_ack_t s_ack_data,

    output logic                         m_req_valid,
    input  wire logic                    m_req_ready,
    output rdma_pkt_pkg::rdma_req_t      m_req_data
);

    logic                    trk_ack_valid;
    logic                    trk_ack_ready;
    rdma_pkt_pkg::rdma_ack_t trk_ack_data;

    logic                    out_valid;
    logic                    out_ready;
    rdma_pkt_pkg::rdma_req_t out_data;

    // acks from the receive path, drained every cycle the tracker sees one
    sync_fifo #(
        .item_t    (rdma_pkt_pkg::rdma_ack_t)
    ) u_ack_buf (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (s_ack_valid),
        .in_ready  (s_ack_ready),
        .in_data   (s_ack_data),
        .out_valid (trk_ack_valid),
        .out_ready (trk_ack_ready),
        .out_data  (trk_ack_data)
    );

    msn_tracker u_tracker (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_valid (s_req_valid),
        .req_ready (s_req_ready),
        .req_data  (s_req_data),
        .ack_valid (trk_ack_valid),
        .ack_ready (trk_ack_ready),
        .ack_data  (trk_ack_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    // stamped requests wait here while the transmit side stalls
    sync_fifo #(
        .item_t    (rdma_pkt_pkg::rdma_req_t)
    ) u_req_buf (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (out_valid),
        .in_ready  (out_ready),
        .in_data   (out_data),
        .out_valid (m_req_valid),
        .out_ready (m_req_ready),
        .out_data  (m_req_data)
    );

endmodule

`default_nettype wire

// ==== design/rdma_pkt_pkg.sv ====
`default_nettype none

package rdma_pkt_pkg;

    // request opcodes seen by the tracker
    typedef enum logic [1:0] {
        RC_SEND              = 2'd0,
        RC_RDMA_WRITE        = 2'd1,
        RC_RDMA_READ_REQUEST = 2'd2 // only this one is fenced against plain acks
    } rdma_opcode_e;

    // queue pair id, vfid in the upper bits
    typedef struct packed {
        logic [rdma_cfg_pkg::VFID_BITS-1:0] vfid;
        logic [rdma_cfg_pkg::PID_BITS-1:0]  pid;
    } qp_id_t;

    // request as it travels from the requester to the transmit path
    typedef struct packed {
        rdma_opcode_e                      opcode;
        qp_id_t                            qp;
        logic [15:0]                       len;
        logic [rdma_cfg_pkg::MSN_BITS-1:0] ssn; // filled in by the tracker
    } rdma_req_t;

    // acknowledgement from the receive path, msn is cumulative
    typedef struct packed {
        qp_id_t                            qp;
        logic                              rd; // set when this is a read response
        logic [rdma_cfg_pkg::MSN_BITS-1:0] msn;
    } rdma_ack_t;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type item_t = logic
) (
    input  wire logic  aclk,
    input  wire logic  aresetn,

    input  wire logic  in_valid,
    output logic       in_ready,
    input  wire item_t in_data,

    output logic       out_valid,
    input  wire logic  out_ready,
    output item_t      out_data
);

    item_t mem [rdma_cfg_pkg::FIFO_DEPTH];

    logic [$clog2(rdma_cfg_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(rdma_cfg_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(rdma_cfg_pkg::FIFO_DEPTH+1)-1:0] count;

    logic push;
    logic pop;

    assign in_ready  = (count != rdma_cfg_pkg::FIFO_DEPTH); // low only when full
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr]; // head entry straight from storage

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == rdma_cfg_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == rdma_cfg_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1; // simultaneous push and pop keeps the count
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/rdma_msn_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module msn_tracker_asserts (
    input wire logic aclk,
    input wire logic aresetn,
    input wire logic req_ready,
    input wire logic ack_valid,
    input wire logic ack_ready,
    input wire logic out_valid,
    input wire logic out_ready
);

    // a stamped request only leaves when the request buffer has room
    a_out_room: assert property (@(posedge aclk) disable iff (!aresetn)
        out_valid |-> out_ready)
        else $error("out_valid high while out_ready low");

    a_ack_first: assert property (@(posedge aclk) disable iff (!aresetn)
        ack_valid |-> !req_ready)
        else $error("req_ready high while an ack is offered");

    a_ack_not_stalled: assert property (@(posedge aclk) disable iff (!aresetn)
        ack_ready == ack_valid)
        else $error("ack_ready does not follow ack_valid");

endmodule

bind msn_tracker msn_tracker_asserts u_asserts (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_ready (req_ready),
    .ack_valid (ack_valid),
    .ack_ready (ack_ready),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

// ==== tests/tb_rdma_msn.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rdma_msn;

    localparam int PERIOD = 40;
    localparam int SEED = 32'h1910_edc0;
    localparam int BUDGET_CYCLES = 500 + 1100 + 800 + 900 + 500 + 3000; // per test, in run order

    logic                    aclk;
    logic                    aresetn;
    logic                    s_req_valid;
    logic                    s_req_ready;
    rdma_pkt_pkg::rdma_req_t s_req_data;
    logic                    s_ack_valid;
    logic                    s_ack_ready;
    rdma_pkt_pkg::rdma_ack_t s_ack_data;
    logic                    m_req_valid;
    logic                    m_req_ready;
    rdma_pkt_pkg::rdma_req_t m_req_data;

    rdma_pkt_pkg::rdma_req_t got_q [$]; // popped from m_req
    rdma_pkt_pkg::rdma_req_t exp_q [$]; // accepted requests with the ssn they should carry
    int   exp_ssn [rdma_cfg_pkg::N_QP];
    int   errors = 0;
    int   err_base = 0;
    int   pass_cnt = 0;
    int   fail_cnt = 0;
    logic stall_on;
    logic blocked_seen;

    rdma_msn_top dut (.*);

    always #(PERIOD / 2) aclk = ~aclk;

    always @(posedge aclk) begin
        if (aresetn && m_req_valid && m_req_ready) begin
            got_q.push_back(m_req_data);
        end
        if (s_req_valid && !s_req_ready) begin
            blocked_seen = 1'b1;
        end
    end

    always @(posedge aclk) begin
        #2;
        m_req_ready = stall_on ? (($urandom % 4) == 0) : 1'b1; // one beat in four while stalling
    end

    task automatic check_req(input string name, input rdma_pkt_pkg::rdma_req_t got,
                             input rdma_pkt_pkg::rdma_req_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == err_base) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    // offers up to n requests and stops at the first one not taken within max_wait cycles
    task automatic try_reqs(input int qp, input rdma_pkt_pkg::rdma_opcode_e op, input int n,
                            input int max_wait, output int accepted);
        rdma_pkt_pkg::rdma_req_t req;
        logic hit;
        accepted = 0;
        for (int i = 0; i < n; i++) begin
            req = {op, 5'(qp), 16'($urandom % 2048 + 1), 24'($urandom)};
            s_req_data = req;
            s_req_valid = 1'b1;
            hit = 1'b0;
            for (int c = 0; c < max_wait && !hit; c++) begin
                @(posedge aclk);
                hit = s_req_ready;
            end
            #2;
            if (!hit) begin
                break;
            end
            req.ssn = 24'(exp_ssn[qp]); // each queue pair counts from zero on its own
            exp_ssn[qp]++;
            exp_q.push_back(req);
            accepted++;
        end
        s_req_valid = 1'b0;
    endtask

    task automatic send_ack(input int qp, input logic rd, input int msn);
        logic hit;
        s_ack_data = {5'(qp), rd, 24'(msn)};
        s_ack_valid = 1'b1;
        hit = 1'b0;
        for (int c = 0; c < 16 && !hit; c++) begin
            @(posedge aclk);
            hit = s_ack_ready;
        end
        #2;
        s_ack_valid = 1'b0;
        if (!hit) begin
            $display("the ack buffer did not take the ack for queue pair %0d", qp);
            errors++;
        end
    endtask

    task automatic drain_check(input string what);
        int c;
        c = 0;
        while (got_q.size() < exp_q.size() && c < 400) begin
            @(posedge aclk);
            #2;
            c++;
        end
        if (got_q.size() != exp_q.size()) begin
            $display("%s: %0d requests were expected on m_req but %0d arrived",
                     what, exp_q.size(), got_q.size());
            errors++;
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            check_req({what, " m_req_data"}, got_q.pop_front(), exp_q.pop_front());
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic test_stamping();
        int n;
        int total;
        total = 0;
        for (int r = 0; r < 3; r++) begin
            for (int q = 0; q < 4; q++) begin
                try_reqs(q, rdma_pkt_pkg::rdma_opcode_e'((r + q) % 3), 1, 8, n);
                total += n;
            end
        end
        check_count("requests accepted", total, 12);
        drain_check("stamping");
        report_test("sequence_stamping");
    endtask

    task automatic test_window();
        int n;
        try_reqs(4, rdma_pkt_pkg::RC_SEND, 32, 8, n);
        check_count("accepted on qp 4", n, 32);
        drain_check("window fill");
        try_reqs(4, rdma_pkt_pkg::RC_SEND, 1, 20, n); // the 33rd must be held
        check_count("accepted past a full window", n, 0);
        check_count("m_req beats while held", got_q.size(), 0);
        try_reqs(5, rdma_pkt_pkg::RC_SEND, 1, 8, n);
        check_count("accepted on qp 5", n, 1);
        drain_check("window other qp");
        report_test("window_limit");
    endtask

    task automatic test_retire();
        int n;
        send_ack(4, 1'b0, 5);
        try_reqs(4, rdma_pkt_pkg::RC_SEND, 10, 8, n);
        check_count("freed by msn 5", n, 5);
        send_ack(4, 1'b0, 32);
        try_reqs(4, rdma_pkt_pkg::RC_SEND, 32, 8, n);
        check_count("freed by msn 32", n, 27);
        drain_check("retire");
        report_test("cumulative_retire");
    endtask

    task automatic test_fencing();
        int n;
        int total;
        try_reqs(6, rdma_pkt_pkg::RC_RDMA_WRITE, 3, 8, total);
        try_reqs(6, rdma_pkt_pkg::RC_RDMA_READ_REQUEST, 1, 8, n);
        total += n;
        try_reqs(6, rdma_pkt_pkg::RC_RDMA_WRITE, 28, 8, n);
        check_count("accepted on qp 6", total + n, 32);
        send_ack(6, 1'b0, 10); // plain ack stops in front of the read
        try_reqs(6, rdma_pkt_pkg::RC_RDMA_WRITE, 10, 8, n);
        check_count("freed by plain msn 10", n, 3);
        send_ack(6, 1'b1, 10);
        try_reqs(6, rdma_pkt_pkg::RC_RDMA_WRITE, 10, 8, n);
        check_count("freed by read response msn 10", n, 7);
        drain_check("fencing");
        report_test("read_fencing");
    endtask

    task automatic test_stale();
        int n;
        send_ack(5, 1'b0, 0); // distance 0
        send_ack(5, 1'b1, 2); // distance 2 with 1 outstanding
        try_reqs(5, rdma_pkt_pkg::RC_SEND, rdma_cfg_pkg::WIN_DEPTH, 16, n);
        check_count("accepted after stale acks", n, rdma_cfg_pkg::WIN_DEPTH - 1);
        drain_check("stale");
        report_test("stale_acks");
    endtask

    task automatic test_backpressure();
        int n;
        int total;
        total = 0;
        blocked_seen = 1'b0;
        stall_on = 1'b1;
        for (int i = 0; i < 40; i++) begin
            try_reqs(8 + i % 8, rdma_pkt_pkg::RC_RDMA_WRITE, 1, 64, n);
            total += n;
        end
        stall_on = 1'b0;
        check_count("accepted under stalls", total, 40);
        check_count("s_req_ready drops seen", int'(blocked_seen), 1);
        drain_check("backpressure");
        report_test("back_pressure");
    endtask

    initial begin
        int seed_ret;
        seed_ret = $urandom(SEED); // one seed for the whole run
        aclk = 1'b0;
        aresetn = 1'b0;
        s_req_valid = 1'b0;
        s_req_data = '0;
        s_ack_valid = 1'b0;
        s_ack_data = '0;
        m_req_ready = 1'b1;
        stall_on = 1'b0;
        repeat (8) @(posedge aclk);
        #2;
        aresetn = 1'b1;
        test_stamping();
        test_window();
        test_retire();
        test_fencing();
        test_stale();
        test_backpressure();
        $display("summary: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((BUDGET_CYCLES + 8 + 500) * PERIOD);
        $display("the watchdog expired before the last test finished");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
